// File: build.f
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
dv/mem_model.sv
dv/cache_tb.sv

// File: dv/cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_tb
	import cache_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 4000;
	localparam int LINE_SEL_BITS = 6;

	logic clk;
	logic reset;
	logic enable;
	addr_t addr;
	logic read_write;
	byte_en_t byte_en;
	line_t wdata;
	line_t rdata;
	logic hit;
	logic mem_write_req;
	addr_t mem_write_addr;
	line_t mem_write_data;
	logic mem_write_ack;
	logic mem_read_req;
	addr_t mem_read_addr;
	line_t mem_read_data;
	logic mem_read_ack;
	int read_count;
	int wb_count;
	addr_t wb_last;

	int seed;
	int errors;
	int errors_before;
	int tests;
	int failed_tests;
	int cycles;
	int reads_before;
	int wbs_before;
	line_t shadow [1 << LINE_SEL_BITS];
	line_t expected_q;

	cache_top u_dut (.*);

	mem_model u_mem (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Limit from about 200 accesses at up to 14 cycles each
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles without a result", cycles);
		$display("sim failed");
		$finish;
	end

	// Expected line of the access on this edge, checked when hit follows
	always @(posedge clk) begin
		expected_q <= shadow[addr[OFFSET_BITS +: LINE_SEL_BITS]];
	end

	assert property (@(negedge clk) disable iff (reset) hit |-> rdata == expected_q)
		else begin
			errors++;
			$display("MISMATCH time=%0t rdata expected=%h actual=%h", $time, expected_q, rdata);
		end

	assert property (@(negedge clk) disable iff (reset) !(mem_write_req && mem_read_req))
		else begin
			errors++;
			$display("Both memory requests were high at time %0t", $time);
		end

	function automatic line_t merge_bytes(line_t old_line, line_t data, byte_en_t be);
		line_t result;
		result = old_line;
		for (int i = 0; i < LINE_BITS/8; i++) begin
			if (be[i]) begin
				result[8*i +: 8] = data[8*i +: 8];
			end
		end
		return result;
	endfunction

	// Holds one request until hit, from a falling edge to a falling edge
	task automatic access(input int line_no, input logic is_read, input byte_en_t be,
		input line_t data);
		if (!is_read) begin
			shadow[line_no] = merge_bytes(shadow[line_no], data, be);
		end
		addr = addr_t'(line_no) << OFFSET_BITS;
		read_write = is_read;
		byte_en = be;
		wdata = data;
		enable = 1'b1;
		do begin
			@(negedge clk);
		end while (!hit);
		enable = 1'b0;
	endtask

	task automatic read_line(input int line_no);
		access(line_no, 1'b1, '0, '0);
	endtask

	task automatic write_line(input int line_no);
		byte_en_t be;
		line_t data;
		be = byte_en_t'($random(seed));
		data = {$random(seed), $random(seed), $random(seed), $random(seed)};
		access(line_no, 1'b0, be, data);
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			errors++;
			$display("Check failed at time %0t: %s", $time, what);
		end
	endtask

	task automatic check_value(input string name, input line_t expected, input line_t actual);
		assert (actual == expected) else begin
			errors++;
			$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
		end
	endtask

	task automatic end_test(input string name);
		// One more edge so the last hit check lands in this test
		@(negedge clk);
		tests++;
		if (errors != errors_before) begin
			failed_tests++;
		end
		$display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "failed");
		errors_before = errors;
	endtask

	initial begin
		seed = 32'h8bd1;
		errors = 0;
		errors_before = 0;
		tests = 0;
		failed_tests = 0;
		reset = 1'b1;
		enable = 1'b0;
		addr = '0;
		read_write = 1'b1;
		byte_en = '0;
		wdata = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < (1 << LINE_SEL_BITS); i++) begin
			shadow[i] = u_mem.mem[i];
		end

		check_true(!hit && !mem_write_req && !mem_read_req, "outputs not low after reset");
		reads_before = read_count;
		read_line(5);
		check_true(read_count == reads_before + 1, "first read did not fetch exactly one line");
		end_test("reset and first read");

		// Line 5 is cached already, line 9 shares its index
		reads_before = read_count;
		write_line(5);
		read_line(5);
		check_true(read_count == reads_before, "hits on line 5 read from memory");
		write_line(9);
		write_line(9);
		read_line(9);
		check_true(read_count == reads_before + 1, "line 9 was fetched more than once");
		end_test("write merge");

		// Index 2, line 2 ends up dirty and least recently used
		wbs_before = wb_count;
		write_line(2);
		read_line(6);
		read_line(10);
		check_true(wb_count == wbs_before + 1, "dirty victim was not written back");
		check_value("mem_write_addr", line_t'(2 << OFFSET_BITS), line_t'(wb_last));
		check_value("mem line 2", shadow[2], u_mem.mem[2]);
		read_line(14);
		check_true(wb_count == wbs_before + 1, "clean victim was written back");
		end_test("eviction");

		read_line(3);
		read_line(7);
		read_line(3);
		read_line(11);
		reads_before = read_count;
		read_line(3);
		check_true(read_count == reads_before, "recently used line 3 was evicted");
		read_line(7);
		check_true(read_count == reads_before + 1, "least recently used line 7 was kept");
		end_test("lru order");

		// Lines 16 to 31 give four tags on every index
		repeat (150) begin
			if (($random(seed) & 1) == 1) begin
				read_line(16 + ($random(seed) & 15));
			end else begin
				write_line(16 + ($random(seed) & 15));
			end
		end
		end_test("random mix");

		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module mem_model
	import cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic mem_write_req,
	input addr_t mem_write_addr,
	input line_t mem_write_data,
	output logic mem_write_ack,
	input logic mem_read_req,
	input addr_t mem_read_addr,
	output line_t mem_read_data,
	output logic mem_read_ack,
	output int read_count,
	output int wb_count,
	output addr_t wb_last
);

	localparam int LINE_SEL_BITS = 6;

	line_t mem [1 << LINE_SEL_BITS];
	int seed;
	int wait_cycles;
	logic busy;

	initial begin
		seed = 32'h8bd1;
		mem_write_ack <= 1'b0;
		mem_read_ack <= 1'b0;
		mem_read_data <= '0;
		for (int i = 0; i < (1 << LINE_SEL_BITS); i++) begin
			mem[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
		end
	end

	// One request at a time, acked 1 to 4 cycles after it is seen
	always @(posedge clk) begin
		mem_write_ack <= 1'b0;
		mem_read_ack <= 1'b0;
		if (reset) begin
			busy <= 1'b0;
			wait_cycles <= 0;
			read_count <= 0;
			wb_count <= 0;
			wb_last <= '0;
		end else if (mem_write_ack || mem_read_ack) begin
			// Request drops on this edge
			busy <= 1'b0;
		end else if (!busy) begin
			if (mem_write_req || mem_read_req) begin
				busy <= 1'b1;
				wait_cycles <= $random(seed) & 3;
			end
		end else if (wait_cycles > 0) begin
			wait_cycles <= wait_cycles - 1;
		end else if (mem_write_req) begin
			mem[mem_write_addr[OFFSET_BITS +: LINE_SEL_BITS]] = mem_write_data;
			wb_count <= wb_count + 1;
			wb_last <= mem_write_addr;
			mem_write_ack <= 1'b1;
		end else begin
			mem_read_data <= mem[mem_read_addr[OFFSET_BITS +: LINE_SEL_BITS]];
			read_count <= read_count + 1;
			mem_read_ack <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module cache_tb -f build.f || exit 1
out=$(./obj_dir/Vcache_tb)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl
	import cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic enable,
	input addr_t addr,
	input logic read_write,
	input byte_en_t byte_en,
	input line_t wdata,
	output line_t rdata,
	output logic hit,
	input way_status_t status0,
	input way_status_t status1,
	output way_write_t wr0,
	output way_write_t wr1,
	output logic mem_write_req,
	output addr_t mem_write_addr,
	output line_t mem_write_data,
	input logic mem_write_ack,
	output logic mem_read_req,
	output addr_t mem_read_addr,
	input line_t mem_read_data,
	input logic mem_read_ack
);

	ctrl_state_t state;

	// One bit per index, naming the least recently used way
	logic [LINES_PER_WAY-1:0] lru_bits;

	logic [NUM_WAYS-1:0] way_match;
	logic any_hit;
	logic hit_way;
	logic hit_access;
	logic miss_start;
	logic victim_sel;
	logic victim;
	logic wr_sel;
	index_t index;
	tag_t tag;
	index_t req_index;
	tag_t req_tag;
	addr_t req_addr;
	line_t hit_line;
	line_t byte_mask;
	line_t merged_line;
	way_status_t victim_status;
	way_write_t wr_next;

	assign index = addr[OFFSET_BITS +: INDEX_BITS];
	assign tag = addr[ADDR_BITS-1 -: TAG_BITS];
	assign req_index = req_addr[OFFSET_BITS +: INDEX_BITS];
	assign req_tag = req_addr[ADDR_BITS-1 -: TAG_BITS];

	// Hit combining
	assign way_match = {status1.match, status0.match};
	assign any_hit = |way_match;
	assign hit_way = way_match[1];
	assign hit_line = hit_way ? status1.line : status0.line;

	assign hit_access = (state == IDLE) && enable && any_hit;
	assign miss_start = (state == IDLE) && enable && !any_hit;

	// Byte merge of write data into the hitting line
	always_comb begin
		for (int i = 0; i < LINE_BITS/8; i++) begin
			byte_mask[8*i +: 8] = {8{byte_en[i]}};
		end
	end

	assign merged_line = (hit_line & ~byte_mask) | (wdata & byte_mask);

	// Invalid ways first, then the LRU way of the index
	always_comb begin
		if (!status0.valid) begin
			victim_sel = 1'b0;
		end else if (!status1.valid) begin
			victim_sel = 1'b1;
		end else begin
			victim_sel = lru_bits[index];
		end
	end

	assign victim_status = victim_sel ? status1 : status0;

	assign mem_read_addr = {req_addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

	// Way updates, write hit in IDLE or line fill on the read ack
	always_comb begin
		wr_next = '0;
		wr_sel = 1'b0;
		if (hit_access && !read_write) begin
			wr_next.we = 1'b1;
			wr_next.index = index;
			wr_next.tag = tag;
			wr_next.valid = 1'b1;
			wr_next.dirty = 1'b1;
			wr_next.line = merged_line;
			wr_sel = hit_way;
		end else if (state == FILL && mem_read_ack) begin
			wr_next.we = 1'b1;
			wr_next.index = req_index;
			wr_next.tag = req_tag;
			wr_next.valid = 1'b1;
			wr_next.dirty = 1'b0;
			wr_next.line = mem_read_data;
			wr_sel = victim;
		end
		wr0 = wr_next;
		wr1 = wr_next;
		wr0.we = wr_next.we && !wr_sel;
		wr1.we = wr_next.we && wr_sel;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			hit <= 1'b0;
			rdata <= '0;
			lru_bits <= '0;
			mem_write_req <= 1'b0;
			mem_read_req <= 1'b0;
		end else begin
			hit <= hit_access;
			case (state)
				IDLE: begin
					if (hit_access) begin
						rdata <= read_write ? hit_line : merged_line;
						lru_bits[index] <= ~hit_way;
					end else if (miss_start) begin
						if (victim_status.valid && victim_status.dirty) begin
							mem_write_req <= 1'b1;
							state <= WRITE_BACK;
						end else begin
							mem_read_req <= 1'b1;
							state <= FILL;
						end
					end
				end
				WRITE_BACK: begin
					if (mem_write_ack) begin
						mem_write_req <= 1'b0;
						mem_read_req <= 1'b1;
						state <= FILL;
					end
				end
				FILL: begin
					if (mem_read_ack) begin
						mem_read_req <= 1'b0;
						lru_bits[req_index] <= ~victim;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Miss context, captured once and held through the memory handshakes
	always_ff @(posedge clk) begin
		if (miss_start) begin
			victim <= victim_sel;
			req_addr <= addr;
			mem_write_addr <= {victim_status.tag, index, {OFFSET_BITS{1'b0}}};
			mem_write_data <= victim_status.line;
		end
	end

	// A tag lives in at most one way of an index
	assert property (@(posedge clk) disable iff (reset)
		!(status0.match && status1.match));

	assert property (@(posedge clk) disable iff (reset)
		!(mem_write_req && mem_read_req));

	// Requests hold until acknowledged
	assert property (@(posedge clk) disable iff (reset)
		(mem_write_req && !mem_write_ack) |=> mem_write_req);

	assert property (@(posedge clk) disable iff (reset)
		(mem_read_req && !mem_read_ack) |=> mem_read_req);

endmodule

`default_nettype wire

// File: verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// Geometry
	localparam int ADDR_BITS = 32;
	localparam int LINE_BITS = 128;
	localparam int LINES_PER_WAY = 4;
	localparam int NUM_WAYS = 2;
	localparam int OFFSET_BITS = 4;
	localparam int INDEX_BITS = 2;
	localparam int TAG_BITS = 26;

	// Address is tag, index, offset from the top down
	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [LINE_BITS/8-1:0] byte_en_t;
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [INDEX_BITS-1:0] index_t;

	// Lookup result of one way
	typedef struct packed {
		logic valid;
		logic dirty;
		logic match;
		tag_t tag;
		line_t line;
	} way_status_t;

	// Whole-entry update into one way
	typedef struct packed {
		logic we;
		index_t index;
		tag_t tag;
		logic valid;
		logic dirty;
		line_t line;
	} way_write_t;

	typedef enum logic [1:0] {
		IDLE,
		WRITE_BACK,
		FILL
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top
	import cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic enable,
	input addr_t addr,
	input logic read_write,
	input byte_en_t byte_en,
	input line_t wdata,
	output line_t rdata,
	output logic hit,
	output logic mem_write_req,
	output addr_t mem_write_addr,
	output line_t mem_write_data,
	input logic mem_write_ack,
	output logic mem_read_req,
	output addr_t mem_read_addr,
	input line_t mem_read_data,
	input logic mem_read_ack
);

	index_t lookup_index;
	tag_t lookup_tag;
	way_status_t status0;
	way_status_t status1;
	way_write_t wr0;
	way_write_t wr1;

	// Both ways look up the same entry
	assign lookup_index = addr[OFFSET_BITS +: INDEX_BITS];
	assign lookup_tag = addr[ADDR_BITS-1 -: TAG_BITS];

	cache_way u_way0 (
		.clk(clk),
		.reset(reset),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.status(status0),
		.wr(wr0)
	);

	cache_way u_way1 (
		.clk(clk),
		.reset(reset),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.status(status1),
		.wr(wr1)
	);

	cache_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.addr(addr),
		.read_write(read_write),
		.byte_en(byte_en),
		.wdata(wdata),
		.rdata(rdata),
		.hit(hit),
		.status0(status0),
		.status1(status1),
		.wr0(wr0),
		.wr1(wr1),
		.mem_write_req(mem_write_req),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data),
		.mem_write_ack(mem_write_ack),
		.mem_read_req(mem_read_req),
		.mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data),
		.mem_read_ack(mem_read_ack)
	);

endmodule

`default_nettype wire

// File: verilog/cache_way.sv
`timescale 1ns/1ns
`default_nettype none

module cache_way
	import cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input index_t lookup_index,
	input tag_t lookup_tag,
	output way_status_t status,
	input way_write_t wr
);

	// Per-entry flags
	logic [LINES_PER_WAY-1:0] valid_bits;
	logic [LINES_PER_WAY-1:0] dirty_bits;

	// Entry storage
	tag_t tags [LINES_PER_WAY];
	line_t lines [LINES_PER_WAY];

	logic entry_valid;
	logic entry_dirty;
	tag_t entry_tag;
	line_t entry_line;

	// Addressed entry, read combinationally
	assign entry_valid = valid_bits[lookup_index];
	assign entry_dirty = dirty_bits[lookup_index];
	assign entry_tag = tags[lookup_index];
	assign entry_line = lines[lookup_index];

	always_comb begin
		status.valid = entry_valid;
		status.dirty = entry_dirty;
		status.match = entry_valid && (entry_tag == lookup_tag);
		status.tag = entry_tag;
		status.line = entry_line;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (wr.we) begin
			valid_bits[wr.index] <= wr.valid;
			dirty_bits[wr.index] <= wr.dirty;
		end
	end

	// Tag and line follow the flags in the same cycle
	always_ff @(posedge clk) begin
		if (wr.we) begin
			tags[wr.index] <= wr.tag;
			lines[wr.index] <= wr.line;
		end
	end

	// An invalidated entry cannot carry dirty data
	assert property (@(posedge clk) disable iff (reset)
		(wr.we && !wr.valid) |-> !wr.dirty);

endmodule

`default_nettype wire
